// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= list.f
TB_TOP    ?= tb_cpu
RTL_TOP   ?= cpu_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_top.sv
tb/tb_cpu.sv

// File: rtl/cpu_pkg.sv
package cpu_pkg;

    // datapath widths
    localparam int DATA_W     = 16;
    localparam int INST_W     = 16;
    localparam int PC_W       = 8;
    localparam int REG_ADDR_W = 3;

    // memory depths in words
    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [PC_W-1:0]       pc_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // major opcode in bits 15..11
    typedef enum logic [4:0] {
        op_nop   = 5'b00001,
        op_b     = 5'b00010,
        op_beqz  = 5'b00100,
        op_addiu = 5'b01001,
        op_li    = 5'b01101,
        op_lw    = 5'b10011,
        op_sw    = 5'b11011,
        op_rrr   = 5'b11100
    } opcode_e;

    // function field of op_rrr in bits 1..0
    localparam logic [1:0] FUNC_ADDU = 2'b01;
    localparam logic [1:0] FUNC_SUBU = 2'b11;

    // bubble inserted on flush
    localparam inst_t NOP_INST = {op_nop, 11'b0};

    typedef enum logic [1:0] {alu_add, alu_sub, alu_pass_b} alu_op_e;
    typedef enum logic [1:0] {br_none, br_beqz, br_always} branch_e;
    typedef enum logic [1:0] {fwd_none, fwd_mem, fwd_wb} fwd_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        branch_e   branch;
        reg_addr_t dest;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        reg_addr_t src_a;
        reg_addr_t src_b;
        data_t     val_a;
        data_t     val_b;
        data_t     imm;
        pc_t       pc;
    } id_ex_t;

    typedef struct packed {
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        reg_addr_t dest;
        data_t     result;
        data_t     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t dest;
        data_t     data;
    } mem_wb_t;

endpackage

// File: rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic      clk_50MHz,
    input  logic      rst,
    input  logic      run,
    input  logic      load_en,
    input  pc_t       load_addr,
    input  inst_t     load_inst,
    output logic      wb_en,
    output reg_addr_t wb_reg,
    output data_t     wb_data
);

    inst_t     if_inst;
    pc_t       if_pc;
    ctrl_t     id_ctrl;
    reg_addr_t id_src_a;
    reg_addr_t id_src_b;
    logic      id_uses_a;
    logic      id_uses_b;
    data_t     id_imm;
    data_t     id_val_a;
    data_t     id_val_b;
    logic      stall;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    id_ex_t    ex_stage;
    ex_mem_t   mem_in;
    mem_wb_t   wb_stage;
    logic      redirect;
    pc_t       redirect_pc;

    fetch_stage u_fetch (
        .clk_50MHz   (clk_50MHz),
        .rst         (rst),
        .run         (run),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_inst   (load_inst),
        .if_inst     (if_inst),
        .if_pc       (if_pc)
    );

    decoder u_decoder (
        .inst   (if_inst),
        .ctrl   (id_ctrl),
        .src_a  (id_src_a),
        .src_b  (id_src_b),
        .uses_a (id_uses_a),
        .uses_b (id_uses_b),
        .imm    (id_imm)
    );

    reg_file u_reg_file (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .rd_a      (id_src_a),
        .rd_b      (id_src_b),
        .wb        (wb_stage),
        .val_a     (id_val_a),
        .val_b     (id_val_b)
    );

    hazard_unit u_hazard (
        .id_src_a  (id_src_a),
        .id_src_b  (id_src_b),
        .id_uses_a (id_uses_a),
        .id_uses_b (id_uses_b),
        .ex_stage  (ex_stage),
        .mem_stage (mem_in),
        .wb_stage  (wb_stage),
        .stall     (stall),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b)
    );

    execute_stage u_execute (
        .clk_50MHz   (clk_50MHz),
        .rst         (rst),
        .run         (run),
        .stall       (stall),
        .ctrl        (id_ctrl),
        .src_a       (id_src_a),
        .src_b       (id_src_b),
        .val_a       (id_val_a),
        .val_b       (id_val_b),
        .imm         (id_imm),
        .id_pc       (if_pc),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .wb_stage    (wb_stage),
        .ex_stage    (ex_stage),
        .mem_in      (mem_in),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    memory_stage u_memory (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .mem_in    (mem_in),
        .wb_out    (wb_stage)
    );

    // every register write is reported
    assign wb_en   = wb_stage.reg_write;
    assign wb_reg  = wb_stage.dest;
    assign wb_data = wb_stage.data;

endmodule

// File: rtl/decoder.sv
`timescale 1ns/1ps

module decoder import cpu_pkg::*; (
    input  inst_t     inst,
    output ctrl_t     ctrl,
    output reg_addr_t src_a,
    output reg_addr_t src_b,
    output logic      uses_a,
    output logic      uses_b,
    output data_t     imm
);

    opcode_e   op;
    reg_addr_t rx;
    reg_addr_t ry;
    reg_addr_t rz;

    assign op = opcode_e'(inst[15:11]);
    assign rx = inst[10:8];
    assign ry = inst[7:5];
    assign rz = inst[4:2];

    // operands always come from rx and ry
    assign src_a = rx;
    assign src_b = ry;

    always_comb begin
        ctrl   = '0;
        uses_a = 1'b0;
        uses_b = 1'b0;
        imm    = '0;
        case (op)
            op_rrr: begin
                // unknown function codes fall back to nop
                if (inst[1:0] == FUNC_ADDU || inst[1:0] == FUNC_SUBU) begin
                    ctrl.alu_op    = (inst[1:0] == FUNC_SUBU) ? alu_sub : alu_add;
                    ctrl.reg_write = 1'b1;
                    ctrl.dest      = rz;
                    uses_a         = 1'b1;
                    uses_b         = 1'b1;
                end
            end
            op_addiu: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest      = rx;
                uses_a         = 1'b1;
                imm            = data_t'(signed'(inst[7:0]));
            end
            op_li: begin
                ctrl.alu_op    = alu_pass_b;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest      = rx;
                imm            = {8'b0, inst[7:0]};
            end
            op_lw: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dest      = ry;
                uses_a         = 1'b1;
                imm            = data_t'(signed'(inst[4:0]));
            end
            op_sw: begin
                // ry is the store data
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                uses_a         = 1'b1;
                uses_b         = 1'b1;
                imm            = data_t'(signed'(inst[4:0]));
            end
            op_beqz: begin
                ctrl.branch = br_beqz;
                uses_a      = 1'b1;
                imm         = data_t'(signed'(inst[7:0]));
            end
            op_b: begin
                ctrl.branch = br_always;
                imm         = data_t'(signed'(inst[10:0]));
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input  logic      clk_50MHz,
    input  logic      rst,
    input  logic      run,
    input  logic      stall,
    input  ctrl_t     ctrl,
    input  reg_addr_t src_a,
    input  reg_addr_t src_b,
    input  data_t     val_a,
    input  data_t     val_b,
    input  data_t     imm,
    input  pc_t       id_pc,
    input  fwd_sel_e  fwd_a,
    input  fwd_sel_e  fwd_b,
    input  mem_wb_t   wb_stage,
    output id_ex_t    ex_stage,
    output ex_mem_t   mem_in,
    output logic      redirect,
    output pc_t       redirect_pc
);

    data_t op_a;
    data_t op_b;
    data_t alu_b;
    data_t result;

    function automatic data_t pick(fwd_sel_e sel, data_t reg_val, data_t mem_val,
                                   data_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    // ID/EX register takes a bubble on stall, flush or hold
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            ex_stage <= '0;
        end else if (!run || redirect || stall) begin
            ex_stage <= '0;
        end else begin
            ex_stage <= '{ctrl: ctrl, src_a: src_a, src_b: src_b, val_a: val_a,
                          val_b: val_b, imm: imm, pc: id_pc};
        end
    end

    assign op_a  = pick(fwd_a, ex_stage.val_a, mem_in.result, wb_stage.data);
    assign op_b  = pick(fwd_b, ex_stage.val_b, mem_in.result, wb_stage.data);
    assign alu_b = ex_stage.ctrl.use_imm ? ex_stage.imm : op_b;

    always_comb begin
        case (ex_stage.ctrl.alu_op)
            alu_sub:    result = op_a - alu_b;
            alu_pass_b: result = alu_b;
            default:    result = op_a + alu_b;
        endcase
    end

    // target is branch address + 1 + offset
    assign redirect = (ex_stage.ctrl.branch == br_always) ||
                      (ex_stage.ctrl.branch == br_beqz && op_a == '0);
    assign redirect_pc = ex_stage.pc + pc_t'(1) + ex_stage.imm[PC_W-1:0];

    // EX/MEM register
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            mem_in <= '0;
        end else if (!run) begin
            mem_in <= '0;
        end else begin
            mem_in <= '{mem_read: ex_stage.ctrl.mem_read,
                        mem_write: ex_stage.ctrl.mem_write,
                        reg_write: ex_stage.ctrl.reg_write,
                        dest: ex_stage.ctrl.dest,
                        result: result,
                        store_data: op_b};
        end
    end

endmodule

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; (
    input  logic  clk_50MHz,
    input  logic  rst,
    input  logic  run,
    input  logic  stall,
    input  logic  redirect,
    input  pc_t   redirect_pc,
    input  logic  load_en,
    input  pc_t   load_addr,
    input  inst_t load_inst,
    output inst_t if_inst,
    output pc_t   if_pc
);

    pc_t   pc;
    inst_t imem [IMEM_DEPTH];
    inst_t fetched;

    // program is written only while the core is held
    always_ff @(posedge clk_50MHz) begin
        if (load_en) begin
            imem[load_addr] <= load_inst;
        end
    end

    assign fetched = imem[pc];

    // redirect wins over stall
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc + pc_t'(1);
        end
    end

    // IF/ID register
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            if_inst <= NOP_INST;
            if_pc   <= '0;
        end else if (!run || redirect) begin
            if_inst <= NOP_INST;
            if_pc   <= '0;
        end else if (!stall) begin
            if_inst <= fetched;
            if_pc   <= pc;
        end
    end

endmodule

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
    input  reg_addr_t id_src_a,
    input  reg_addr_t id_src_b,
    input  logic      id_uses_a,
    input  logic      id_uses_b,
    input  id_ex_t    ex_stage,
    input  ex_mem_t   mem_stage,
    input  mem_wb_t   wb_stage,
    output logic      stall,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b
);

    logic dep_a;
    logic dep_b;

    // load in EX feeding the instruction in ID
    assign dep_a = id_uses_a && (id_src_a == ex_stage.ctrl.dest);
    assign dep_b = id_uses_b && (id_src_b == ex_stage.ctrl.dest);
    assign stall = ex_stage.ctrl.mem_read && (dep_a || dep_b);

    // youngest producer first
    always_comb begin
        fwd_a = fwd_none;
        if (mem_stage.reg_write && mem_stage.dest == ex_stage.src_a) begin
            fwd_a = fwd_mem;
        end else if (wb_stage.reg_write && wb_stage.dest == ex_stage.src_a) begin
            fwd_a = fwd_wb;
        end
    end

    always_comb begin
        fwd_b = fwd_none;
        if (mem_stage.reg_write && mem_stage.dest == ex_stage.src_b) begin
            fwd_b = fwd_mem;
        end else if (wb_stage.reg_write && wb_stage.dest == ex_stage.src_b) begin
            fwd_b = fwd_wb;
        end
    end

endmodule

// File: rtl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import cpu_pkg::*; (
    input  logic    clk_50MHz,
    input  logic    rst,
    input  ex_mem_t mem_in,
    output mem_wb_t wb_out
);

    data_t                          dmem [DMEM_DEPTH];
    logic [$clog2(DMEM_DEPTH)-1:0]  addr;
    data_t                          rd_data;

    // only the low byte of the ALU result addresses memory
    assign addr    = mem_in.result[$clog2(DMEM_DEPTH)-1:0];
    assign rd_data = dmem[addr];

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_in.mem_write) begin
            dmem[addr] <= mem_in.store_data;
        end
    end

    // MEM/WB register
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            wb_out <= '0;
        end else begin
            wb_out.reg_write <= mem_in.reg_write;
            wb_out.dest      <= mem_in.dest;
            wb_out.data      <= mem_in.mem_read ? rd_data : mem_in.result;
        end
    end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
    input  logic      clk_50MHz,
    input  logic      rst,
    input  reg_addr_t rd_a,
    input  reg_addr_t rd_b,
    input  mem_wb_t   wb,
    output data_t     val_a,
    output data_t     val_b
);

    data_t regs [2**REG_ADDR_W];

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // same-cycle write shows up on the read ports
    assign val_a = (wb.reg_write && wb.dest == rd_a) ? wb.data : regs[rd_a];
    assign val_b = (wb.reg_write && wb.dest == rd_b) ? wb.data : regs[rd_b];

endmodule

// File: tb/cpu_tests.txt
# P <word count> then the instruction words in hex
# E <write count> then <reg> <value> pairs in hex, in report order
# LI, ADDIU, ADDU, SUBU with back-to-back forwarding and 16-bit wrap
P 9
697F 6AFF E14D E173 4C80 6D01 4DFE E5B9 17FF
E 8
1 007F  2 00FF  3 017E  4 FF01
4 FE81  5 0001  5 FFFF  6 FFFE
# SW then LW at another base and offset, ADDU right after the load
P 7
6910 6AA5 D943 6B16 9B9D E435 17FF
E 5
1 0010  2 00A5  3 0016  4 00A5  5 00B5
# BEQZ taken skips two, BEQZ on nonzero falls through
P 9
6900 2102 6A11 6B22 6C33 2402 6D44 E4B9 17FF
E 4
1 0000  4 0033  5 0044  6 0077
# countdown loop closed by B with a negative offset
P 8
6903 6A00 4A05 49FF 2101 17FC 6F5A 17FF
E 9
1 0003  2 0000
2 0005  1 0002
2 000A  1 0001
2 000F  1 0000
7 005A
# NOP and unknown opcodes write nothing, r0 is an ordinary register
P 10
6921 0800 0000 6A42 F8FF E14C E14D 3AAA E223 17FF
E 4
1 0021  2 0042  3 0063  0 0021

// File: tb/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

    logic      clk_50MHz;
    logic      rst;
    logic      run;
    logic      load_en;
    pc_t       load_addr;
    inst_t     load_inst;
    logic      wb_en;
    reg_addr_t wb_reg;
    data_t     wb_data;

    // programs and expected writes kept in flat queues
    inst_t     prog_words[$];
    int        prog_start[$];
    int        prog_len[$];
    reg_addr_t exp_reg[$];
    data_t     exp_data[$];
    int        exp_start[$];
    int        exp_len[$];

    int error_count;
    int check_count;
    int cycle_count;
    int cycle_limit;

    cpu_top UUT (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .run       (run),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_inst (load_inst),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data)
    );

    always #10 clk_50MHz = ~clk_50MHz;

    task automatic finish_run();
        $display("tests: %0d, checks: %0d, errors: %0d",
                 prog_len.size(), check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    always @(posedge clk_50MHz) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the expected write-backs never arrived",
                     cycle_count);
            error_count = error_count + 1;
            finish_run();
        end
    end

    // inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_50MHz);
        #2;
    endtask

    task automatic check_reg(input int t, input int idx, input reg_addr_t got,
                             input reg_addr_t exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("MISMATCH test %0d write %0d: wb_reg got %h expected %h",
                     t, idx, got, exp);
        end
    endtask

    task automatic check_data(input int t, input int idx, input data_t got,
                              input data_t exp);
        check_count = check_count + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("MISMATCH test %0d write %0d: wb_data got %h expected %h",
                     t, idx, got, exp);
        end
    endtask

    task automatic read_tests();
        int          fd;
        int          c;
        int          n;
        int          code;
        logic [31:0] hex_a;
        logic [31:0] hex_b;
        fd = $fopen("tb/cpu_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file tb/cpu_tests.txt");
            error_count = error_count + 1;
            return;
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == int'("#")) begin
                // skip comment to end of line
                while (c != -1 && c != int'("\n")) begin
                    c = $fgetc(fd);
                end
            end else if (c == int'("P")) begin
                code = $fscanf(fd, "%d", n);
                prog_start.push_back(prog_words.size());
                prog_len.push_back(n);
                for (int i = 0; i < n; i++) begin
                    code = $fscanf(fd, "%h", hex_a);
                    if (code != 1) begin
                        $display("program %0d in the test file is cut short", prog_len.size());
                        error_count = error_count + 1;
                    end
                    prog_words.push_back(inst_t'(hex_a));
                end
            end else if (c == int'("E")) begin
                code = $fscanf(fd, "%d", n);
                exp_start.push_back(exp_reg.size());
                exp_len.push_back(n);
                for (int i = 0; i < n; i++) begin
                    code = $fscanf(fd, "%h %h", hex_a, hex_b);
                    if (code != 2) begin
                        $display("expected list %0d in the test file is cut short",
                                 exp_len.size());
                        error_count = error_count + 1;
                    end
                    exp_reg.push_back(reg_addr_t'(hex_a));
                    exp_data.push_back(data_t'(hex_b));
                end
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
        if (prog_len.size() != exp_len.size()) begin
            $display("test file has %0d programs but %0d expected lists",
                     prog_len.size(), exp_len.size());
            error_count = error_count + 1;
        end
    endtask

    task automatic run_test(input int t);
        int got;
        int gap;
        int base;
        got  = 0;
        base = exp_start[t];
        // hold the core and reset it
        next_cycle();
        run     = 1'b0;
        load_en = 1'b0;
        rst     = 1'b0;
        repeat (5) next_cycle();
        rst = 1'b1;
        for (int i = 0; i < prog_len[t]; i++) begin
            load_en   = 1'b1;
            load_addr = pc_t'(i);
            load_inst = prog_words[prog_start[t] + i];
            next_cycle();
        end
        load_en = 1'b0;
        gap = int'($urandom % 4);
        repeat (gap) next_cycle();
        run = 1'b1;
        // reports are sampled mid-cycle
        while (got < exp_len[t]) begin
            @(negedge clk_50MHz);
            if (wb_en) begin
                check_reg(t, got, wb_reg, exp_reg[base + got]);
                check_data(t, got, wb_data, exp_data[base + got]);
                got = got + 1;
            end
        end
    endtask

    initial begin
        clk_50MHz   = 1'b0;
        rst         = 1'b0;
        run         = 1'b0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_inst   = '0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        cycle_limit = 0;
        void'($urandom(32'hba66));
        read_tests();
        cycle_limit = 20 + 8 * prog_words.size();
        if (prog_len.size() == exp_len.size()) begin
            for (int t = 0; t < prog_len.size(); t++) begin
                run_test(t);
            end
        end
        finish_run();
    end

endmodule
